// File: flist.f
common/frame_reader_pkg.sv
common/frame_stream_if.sv
mm2fifo/frame_reader_regs.sv
mm2fifo/frame_read_master.sv
design/stream_fifo.sv
design/frame_reader_top.sv
sim/axi_mem_model.sv
sim/tb_frame_reader.sv

// File: Bender.yml
package:
  name: frame_reader

sources:
  - common/frame_reader_pkg.sv
  - common/frame_stream_if.sv
  - mm2fifo/frame_reader_regs.sv
  - mm2fifo/frame_read_master.sv
  - design/stream_fifo.sv
  - design/frame_reader_top.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/tb_frame_reader.sv

// File: sim/tb_frame_reader.sv
`timescale 1ns/1ps
/*
 * Frame reader testbench
 * Runs random frames through the DUT against an AXI memory model and
 * checks every output beat and AR request against a reference model.
 */
module tb_frame_reader import frame_reader_pkg::*; ();

	localparam int          BURST_LEN   = 16;
	localparam int          FIFO_DEPTH  = 32;
	localparam int          BURST_BYTES = BURST_LEN * DATA_WIDTH / 8;
	localparam int          MAX_AHEAD   = (FIFO_DEPTH + BURST_LEN - 1) / BURST_LEN;
	localparam int          NUM_FRAMES  = 10;
	localparam int          SRST_FRAME  = 8;
	localparam logic [31:0] SEED        = 32'h7945;

	logic                  M_AXI_ACLK = 1'b0;
	logic                  M_AXI_ARESETN = 1'b0;
	logic                  soft_reset = 1'b0;
	logic                  fsync = 1'b0;
	logic [ADDR_WIDTH-1:0] cfg_base_addr = '0;
	logic [IMG_WBITS-1:0]  cfg_width = '0;
	logic [IMG_HBITS-1:0]  cfg_height = '0;
	logic                  out_ready = 1'b1;
	logic                  ar_stall = 1'b0;
	logic                  r_stall = 1'b0;
	logic                  resetting, frame_pulse, out_valid, out_sof, out_eol;
	logic [DATA_WIDTH-1:0] out_data;
	logic [ADDR_WIDTH-1:0] M_AXI_ARADDR;
	logic [7:0]            M_AXI_ARLEN;
	logic [2:0]            M_AXI_ARSIZE, M_AXI_ARPROT;
	logic [1:0]            M_AXI_ARBURST, M_AXI_RRESP;
	logic [3:0]            M_AXI_ARCACHE, M_AXI_ARQOS;
	logic                  M_AXI_ARLOCK, M_AXI_ARVALID, M_AXI_ARREADY;
	logic [DATA_WIDTH-1:0] M_AXI_RDATA;
	logic                  M_AXI_RLAST, M_AXI_RVALID, M_AXI_RREADY;

	logic [31:0] rng = SEED;
	logic [31:0] f_base [NUM_FRAMES];
	int          f_wpl [NUM_FRAMES];
	int          f_h [NUM_FRAMES];
	logic [33:0] exp_q [$];
	logic [31:0] cur_base = '0;
	int          cur_words = 0;
	int          frame_ar_beats = 0;
	int          frame_consumed = 0;
	logic        arvalid_d = 1'b0;
	int          ready_mode = 0;
	int          srst_at, total_words, timeout_limit;
	int          cycle_count = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errors_at_start = 0;
	string       cur_test = "reset";

	frame_reader_top #(.BURST_LEN(BURST_LEN), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (.*);
	axi_mem_model mem_i (.*);

	always #2 M_AXI_ACLK = ~M_AXI_ACLK;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error: %s %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	// Frame sizes are whole bursts, widths a multiple of 4 pixels
	task automatic build_frame_list();
		total_words = 0;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			rng = lcg(rng);
			f_base[i] = rng & 32'h00FF_FFFF & ~32'(BURST_BYTES - 1);
			rng = lcg(rng);
			if (i == SRST_FRAME) begin
				// Long frame so the soft reset lands mid-frame
				f_wpl[i] = 16;
				f_h[i]   = 8 + 4 * int'(rng[19:18]);
			end else if (rng[20]) begin
				f_wpl[i] = 4 + 4 * int'(rng[17:16]);
				f_h[i]   = 4 + 4 * int'(rng[19:18]);
			end else begin
				f_wpl[i] = 1 + int'(rng[18:16]);
				f_h[i]   = BURST_LEN;
			end
			total_words += f_wpl[i] * f_h[i];
		end
		rng = lcg(rng);
		srst_at = 1 + int'(rng[19:16]);
	endtask

	task automatic drive_cfg(input int idx);
		cfg_base_addr = f_base[idx];
		cfg_width     = IMG_WBITS'(f_wpl[idx] * 4);
		cfg_height    = IMG_HBITS'(f_h[idx]);
	endtask

	// Reference model: one entry of {data, sof, eol} per word
	task automatic start_frame(input int idx);
		@(negedge M_AXI_ACLK);
		drive_cfg(idx);
		cur_base  = f_base[idx];
		cur_words = f_wpl[idx] * f_h[idx];
		for (int i = 0; i < cur_words; i++)
			exp_q.push_back({cur_base + 32'(i * 4), i == 0, (i % f_wpl[idx]) == f_wpl[idx] - 1});
		frame_ar_beats = 0;
		frame_consumed = 0;
		fsync = 1'b1;
		@(posedge M_AXI_ACLK);
		check("frame_pulse", 1, frame_pulse);
		@(negedge M_AXI_ACLK);
		fsync = 1'b0;
	endtask

	// Every beat of the frame was requested, in whole bursts and no more
	task automatic wait_frame_done();
		while (exp_q.size() != 0)
			@(negedge M_AXI_ACLK);
		check("ar beats in frame", cur_words, frame_ar_beats);
	endtask

	task automatic set_ready_mode(input int mode);
		@(posedge M_AXI_ACLK);
		ready_mode = mode;
	endtask

	task automatic pulse_soft_reset();
		@(negedge M_AXI_ACLK);
		soft_reset = 1'b1;
		@(negedge M_AXI_ACLK);
		check("resetting", 1, resetting);
		while (resetting)
			@(negedge M_AXI_ACLK);
		soft_reset = 1'b0;
		// Drain what was pushed before the reset
		set_ready_mode(0);
		do
			@(negedge M_AXI_ACLK);
		while (out_valid);
		if (frame_consumed >= cur_words)
			report_problem("soft reset did not cut the frame short");
		exp_q.delete();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%-14s passed", cur_test);
		end else begin
			tests_failed++;
			$display("%-14s failed with %0d errors", cur_test, errors - errors_at_start);
		end
	endtask

	// Random back-pressure and memory stalls
	always @(negedge M_AXI_ACLK) begin
		rng = lcg(rng);
		ar_stall  = (rng[21:20] == 2'b00);
		r_stall   = (rng[23:22] == 2'b00);
		out_ready = (ready_mode == 0) ? 1'b1 : rng[24];
	end

	// --------------------------------------------------
	// Output and AR monitor
	// --------------------------------------------------
	always @(posedge M_AXI_ACLK) begin
		logic [33:0] exp_beat;
		if (M_AXI_ARESETN) begin
			if (out_valid && out_ready) begin
				frame_consumed++;
				if (exp_q.size() == 0) begin
					report_problem("output beat arrived with no frame pending");
				end else begin
					exp_beat = exp_q.pop_front();
					check("out_data", exp_beat[33:2], out_data);
					check("out_sof", exp_beat[1], out_sof);
					check("out_eol", exp_beat[0], out_eol);
				end
			end
			if (M_AXI_RVALID)
				check("rready", 1, M_AXI_RREADY);
			if (M_AXI_ARVALID && !arvalid_d && resetting)
				report_problem("AR request issued while resetting");
			if (M_AXI_ARVALID && M_AXI_ARREADY) begin
				frame_ar_beats += BURST_LEN;
				check("arlen", BURST_LEN - 1, M_AXI_ARLEN);
				check("arsize", 2, M_AXI_ARSIZE);
				check("arburst", 1, M_AXI_ARBURST);
				check("arlock", 0, M_AXI_ARLOCK);
				check("arcache", 0, M_AXI_ARCACHE);
				check("arprot", 0, M_AXI_ARPROT);
				check("arqos", 0, M_AXI_ARQOS);
				check("araddr alignment", 0, M_AXI_ARADDR % BURST_BYTES);
				check("araddr in frame", 1, M_AXI_ARADDR >= cur_base &&
					M_AXI_ARADDR + BURST_BYTES <= cur_base + cur_words * 4);
				if (frame_ar_beats - frame_consumed > MAX_AHEAD * BURST_LEN)
					report_problem("AR requests ran too far ahead of consumed beats");
			end
			arvalid_d = M_AXI_ARVALID;
		end
	end

	always @(posedge M_AXI_ACLK) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		build_frame_list();
		timeout_limit = 2 * total_words + 2000;
		repeat (3) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
		while (resetting)
			@(negedge M_AXI_ACLK);

		begin_test("data_order");
		start_frame(0);
		wait_frame_done();
		finish_test();

		begin_test("flags");
		for (int i = 1; i <= 2; i++) begin
			start_frame(i);
			wait_frame_done();
		end
		finish_test();

		begin_test("backpressure");
		set_ready_mode(1);
		for (int i = 3; i <= 5; i++) begin
			start_frame(i);
			wait_frame_done();
		end
		finish_test();

		// New values mid-frame only apply from the next fsync
		begin_test("cfg_shadow");
		start_frame(6);
		while (frame_consumed < 4)
			@(negedge M_AXI_ACLK);
		drive_cfg(7);
		wait_frame_done();
		start_frame(7);
		wait_frame_done();
		finish_test();

		begin_test("soft_reset");
		start_frame(SRST_FRAME);
		while (frame_consumed < srst_at)
			@(negedge M_AXI_ACLK);
		pulse_soft_reset();
		set_ready_mode(1);
		start_frame(SRST_FRAME + 1);
		wait_frame_done();
		finish_test();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sim/axi_mem_model.sv
`timescale 1ns/1ps
/*
 * AXI4 read slave model
 * Answers INCR read bursts with the byte address of each beat as data.
 * ARREADY and RVALID are held off by the stall inputs, which are taken
 * on the rising edge and acted on at the next falling edge.
 */
module axi_mem_model import frame_reader_pkg::*; (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  ar_stall,
	input  logic                  r_stall,
	input  logic [ADDR_WIDTH-1:0] M_AXI_ARADDR,
	input  logic [7:0]            M_AXI_ARLEN,
	input  logic                  M_AXI_ARVALID,
	output logic                  M_AXI_ARREADY,
	output logic [DATA_WIDTH-1:0] M_AXI_RDATA,
	output logic [1:0]            M_AXI_RRESP,
	output logic                  M_AXI_RLAST,
	output logic                  M_AXI_RVALID,
	input  logic                  M_AXI_RREADY
);

	localparam int BEAT_BYTES = DATA_WIDTH / 8;

	logic [ADDR_WIDTH-1:0] addr_q [$];
	int                    len_q [$];
	int                    beat_idx = 0;
	logic                  r_taken = 1'b0;
	logic                  ar_stall_q = 1'b1;
	logic                  r_stall_q = 1'b1;

	initial begin
		M_AXI_ARREADY = 1'b0;
		M_AXI_RDATA   = '0;
		M_AXI_RRESP   = 2'b00;
		M_AXI_RLAST   = 1'b0;
		M_AXI_RVALID  = 1'b0;
	end

	// Handshakes seen on this edge
	always @(posedge M_AXI_ACLK) begin
		r_taken    = M_AXI_RVALID && M_AXI_RREADY;
		ar_stall_q = ar_stall;
		r_stall_q  = r_stall;
		if (!M_AXI_ARESETN) begin
			addr_q.delete();
			len_q.delete();
			beat_idx = 0;
		end else begin
			if (M_AXI_ARVALID && M_AXI_ARREADY) begin
				addr_q.push_back(M_AXI_ARADDR);
				len_q.push_back(int'(M_AXI_ARLEN));
			end
			if (r_taken && M_AXI_RLAST) begin
				void'(addr_q.pop_front());
				void'(len_q.pop_front());
				beat_idx = 0;
			end else if (r_taken) begin
				beat_idx++;
			end
		end
	end

	always @(negedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			M_AXI_ARREADY = 1'b0;
			M_AXI_RVALID  = 1'b0;
			M_AXI_RLAST   = 1'b0;
		end else begin
			M_AXI_ARREADY = !ar_stall_q;
			// A beat on offer stays until it is taken
			if (!M_AXI_RVALID || r_taken) begin
				if (addr_q.size() != 0 && !r_stall_q) begin
					M_AXI_RVALID = 1'b1;
					M_AXI_RDATA  = addr_q[0] + ADDR_WIDTH'(beat_idx * BEAT_BYTES);
					M_AXI_RLAST  = (beat_idx == len_q[0]);
				end else begin
					M_AXI_RVALID = 1'b0;
					M_AXI_RLAST  = 1'b0;
				end
			end
		end
	end

endmodule

// File: design/frame_reader_top.sv
`timescale 1ns/1ps
/*
 * Frame reader top level
 * Fetches one image frame per frame sync over an AXI4 read port and
 * delivers it as a valid/ready stream with sof and eol markers.
 */
module frame_reader_top import frame_reader_pkg::*; #(
	parameter int BURST_LEN  = 16,
	parameter int FIFO_DEPTH = 32
) (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  soft_reset,
	input  logic                  fsync,
	input  logic [ADDR_WIDTH-1:0] cfg_base_addr,
	input  logic [IMG_WBITS-1:0]  cfg_width,
	input  logic [IMG_HBITS-1:0]  cfg_height,
	output logic                  resetting,
	output logic                  frame_pulse,
	output logic [ADDR_WIDTH-1:0] M_AXI_ARADDR,
	output logic [7:0]            M_AXI_ARLEN,
	output logic [2:0]            M_AXI_ARSIZE,
	output logic [1:0]            M_AXI_ARBURST,
	output logic                  M_AXI_ARLOCK,
	output logic [3:0]            M_AXI_ARCACHE,
	output logic [2:0]            M_AXI_ARPROT,
	output logic [3:0]            M_AXI_ARQOS,
	output logic                  M_AXI_ARVALID,
	input  logic                  M_AXI_ARREADY,
	input  logic [DATA_WIDTH-1:0] M_AXI_RDATA,
	input  logic [1:0]            M_AXI_RRESP,
	input  logic                  M_AXI_RLAST,
	input  logic                  M_AXI_RVALID,
	output logic                  M_AXI_RREADY,
	output logic                  out_valid,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_sof,
	output logic                  out_eol,
	input  logic                  out_ready
);

	frame_cfg_t   cfg;
	logic         cfg_load;
	logic         soft_reset_req;
	logic         master_idle;
	stream_beat_t fifo_beat;

	frame_stream_if #(.beat_t(stream_beat_t)) beat_if ();

	frame_reader_regs regs_i (
		.M_AXI_ACLK     (M_AXI_ACLK),
		.M_AXI_ARESETN  (M_AXI_ARESETN),
		.soft_reset     (soft_reset),
		.cfg_base_addr  (cfg_base_addr),
		.cfg_width      (cfg_width),
		.cfg_height     (cfg_height),
		.cfg_load       (cfg_load),
		.master_idle    (master_idle),
		.cfg            (cfg),
		.soft_reset_req (soft_reset_req),
		.resetting      (resetting)
	);

	frame_read_master #(
		.BURST_LEN  (BURST_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) master_i (
		.M_AXI_ACLK     (M_AXI_ACLK),
		.M_AXI_ARESETN  (M_AXI_ARESETN),
		.fsync          (fsync),
		.frame_pulse    (frame_pulse),
		.cfg            (cfg),
		.cfg_load       (cfg_load),
		.soft_reset_req (soft_reset_req),
		.master_idle    (master_idle),
		.M_AXI_ARADDR   (M_AXI_ARADDR),
		.M_AXI_ARLEN    (M_AXI_ARLEN),
		.M_AXI_ARSIZE   (M_AXI_ARSIZE),
		.M_AXI_ARBURST  (M_AXI_ARBURST),
		.M_AXI_ARLOCK   (M_AXI_ARLOCK),
		.M_AXI_ARCACHE  (M_AXI_ARCACHE),
		.M_AXI_ARPROT   (M_AXI_ARPROT),
		.M_AXI_ARQOS    (M_AXI_ARQOS),
		.M_AXI_ARVALID  (M_AXI_ARVALID),
		.M_AXI_ARREADY  (M_AXI_ARREADY),
		.M_AXI_RDATA    (M_AXI_RDATA),
		.M_AXI_RRESP    (M_AXI_RRESP),
		.M_AXI_RLAST    (M_AXI_RLAST),
		.M_AXI_RVALID   (M_AXI_RVALID),
		.M_AXI_RREADY   (M_AXI_RREADY),
		.stream         (beat_if.source)
	);

	stream_fifo #(
		.beat_t     (stream_beat_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.in_if         (beat_if.sink),
		.out_valid     (out_valid),
		.out_beat      (fifo_beat),
		.out_ready     (out_ready)
	);

	// Output beat onto plain stream ports
	assign out_data = fifo_beat.data;
	assign out_sof  = fifo_beat.sof;
	assign out_eol  = fifo_beat.eol;

endmodule

// File: design/stream_fifo.sv
`timescale 1ns/1ps
/*
 * Credit-returning stream FIFO
 * Circular buffer in front of a fall-through output register. Every pop
 * hands one credit back to the producer, so a push can never overflow.
 */
module stream_fifo import frame_reader_pkg::*; #(
	parameter type beat_t     = stream_beat_t,
	parameter int  FIFO_DEPTH = 32
) (
	input  logic         M_AXI_ACLK,
	input  logic         M_AXI_ARESETN,
	frame_stream_if.sink in_if,
	output logic         out_valid,
	output beat_t        out_beat,
	input  logic         out_ready
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? clog2_int(FIFO_DEPTH - 1) : 1;
	localparam int CNT_W = clog2_int(FIFO_DEPTH);

	beat_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] mem_count;
	logic             pop;
	logic             load_out;
	logic             take_mem;
	logic             bypass;
	logic             wr_en;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign pop      = out_valid && out_ready;
	assign load_out = !out_valid || pop;
	assign take_mem = load_out && (mem_count != '0);
	// Empty buffer, beat goes straight to the output register
	assign bypass   = load_out && (mem_count == '0) && in_if.push;
	assign wr_en    = in_if.push && !bypass;

	assign in_if.credit = pop;

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			mem_count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_next(wr_ptr);
			if (take_mem)
				rd_ptr <= ptr_next(rd_ptr);
			mem_count <= mem_count + CNT_W'(wr_en) - CNT_W'(take_mem);
			if (load_out)
				out_valid <= take_mem || bypass;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (wr_en)
			mem[wr_ptr] <= in_if.beat;
		if (take_mem)
			out_beat <= mem[rd_ptr];
		else if (bypass)
			out_beat <= in_if.beat;
	end

	// Producer must hold a credit for every push
	a_no_overflow: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		in_if.push |-> (mem_count + out_valid) < FIFO_DEPTH)
		else $error("push into a full FIFO, credit protocol broken");

endmodule

// File: mm2fifo/frame_read_master.sv
`timescale 1ns/1ps
/*
 * Frame read master
 * Walks one image frame with fixed-length AXI4 INCR read bursts, tags
 * each word with sof and eol and pushes it towards the FIFO. A burst is
 * only issued once a full burst of FIFO credits is free.
 */
module frame_read_master import frame_reader_pkg::*; #(
	parameter int BURST_LEN  = 16,
	parameter int FIFO_DEPTH = 32
) (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  fsync,
	output logic                  frame_pulse,
	input  frame_cfg_t            cfg,
	output logic                  cfg_load,
	input  logic                  soft_reset_req,
	output logic                  master_idle,
	output logic [ADDR_WIDTH-1:0] M_AXI_ARADDR,
	output logic [7:0]            M_AXI_ARLEN,
	output logic [2:0]            M_AXI_ARSIZE,
	output logic [1:0]            M_AXI_ARBURST,
	output logic                  M_AXI_ARLOCK,
	output logic [3:0]            M_AXI_ARCACHE,
	output logic [2:0]            M_AXI_ARPROT,
	output logic [3:0]            M_AXI_ARQOS,
	output logic                  M_AXI_ARVALID,
	input  logic                  M_AXI_ARREADY,
	input  logic [DATA_WIDTH-1:0] M_AXI_RDATA,
	input  logic [1:0]            M_AXI_RRESP,
	input  logic                  M_AXI_RLAST,
	input  logic                  M_AXI_RVALID,
	output logic                  M_AXI_RREADY,
	frame_stream_if.source        stream
);

	localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
	localparam int WORD_PIXELS    = BYTES_PER_WORD / pixel_bytes(PIXEL_WIDTH);
	localparam int BURST_BYTES    = BURST_LEN * BYTES_PER_WORD;
	localparam int CNT_W          = clog2_int(FIFO_DEPTH);

	typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_WAIT, ST_ADDR, ST_DATA} state_t;

	state_t                state;
	logic [ADDR_WIDTH-1:0] araddr;
	logic                  arvalid;
	logic [CNT_W-1:0]      credits;
	logic [CNT_W-1:0]      inflight;
	logic [IMG_WBITS-1:0]  col_cnt;
	logic [IMG_HBITS-1:0]  row_cnt;
	logic [IMG_WBITS-1:0]  line_words;
	logic                  first_beat;
	logic                  dropping;
	logic                  beat_seen;
	logic                  push_q;
	stream_beat_t          beat_q;
	logic                  rnext;
	logic                  frame_start;
	logic                  credits_ok;
	logic                  frame_last;
	logic                  burst_done;
	logic                  start_burst;

	assign rnext       = M_AXI_RVALID && M_AXI_RREADY;
	assign burst_done  = rnext && M_AXI_RLAST;
	assign frame_start = (state == ST_IDLE) && fsync && !soft_reset_req;
	assign frame_pulse = frame_start;
	assign cfg_load    = frame_start;
	assign master_idle = (state == ST_IDLE);
	assign line_words  = cfg.width / IMG_WBITS'(WORD_PIXELS);
	assign frame_last  = (col_cnt == '0) && (row_cnt == '0);
	// Free slots not yet promised to a burst
	assign credits_ok  = (credits - inflight) >= CNT_W'(BURST_LEN);
	assign start_burst = !soft_reset_req && credits_ok &&
		((state == ST_LOAD) || (state == ST_WAIT) ||
		((state == ST_DATA) && burst_done && !frame_last && !dropping));

	// --------------------------------------------------
	// AXI read port
	// --------------------------------------------------
	assign M_AXI_ARADDR  = araddr;
	assign M_AXI_ARLEN   = 8'(BURST_LEN - 1);
	assign M_AXI_ARSIZE  = 3'(clog2_int(BYTES_PER_WORD - 1));
	assign M_AXI_ARBURST = 2'b01;
	assign M_AXI_ARLOCK  = 1'b0;
	assign M_AXI_ARCACHE = 4'h0;
	assign M_AXI_ARPROT  = 3'h0;
	assign M_AXI_ARQOS   = 4'h0;
	assign M_AXI_ARVALID = arvalid;
	assign M_AXI_RREADY  = 1'b1;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state    <= ST_IDLE;
			arvalid  <= 1'b0;
			dropping <= 1'b0;
		end else begin
			case (state)
			ST_IDLE:
				if (frame_start)
					state <= ST_LOAD;
			ST_LOAD, ST_WAIT: begin
				if (soft_reset_req) begin
					state <= ST_IDLE;
				end else if (start_burst) begin
					state   <= ST_ADDR;
					arvalid <= 1'b1;
				end else begin
					state <= ST_WAIT;
				end
			end
			ST_ADDR: begin
				// AR must still complete, its data gets thrown away
				if (soft_reset_req)
					dropping <= 1'b1;
				if (M_AXI_ARREADY) begin
					arvalid <= 1'b0;
					state   <= ST_DATA;
				end
			end
			ST_DATA: begin
				if (soft_reset_req)
					dropping <= 1'b1;
				if (burst_done) begin
					if (dropping || soft_reset_req || frame_last) begin
						state    <= ST_IDLE;
						dropping <= 1'b0;
					end else if (start_burst) begin
						state   <= ST_ADDR;
						arvalid <= 1'b1;
					end else begin
						state <= ST_WAIT;
					end
				end
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// Burst address walks upward from the frame base
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			araddr <= '0;
		else if (state == ST_LOAD)
			araddr <= cfg.base_addr;
		else if (arvalid && M_AXI_ARREADY)
			araddr <= araddr + ADDR_WIDTH'(BURST_BYTES);
	end

	// --------------------------------------------------
	// Frame position and beat tagging
	// --------------------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			col_cnt    <= '0;
			row_cnt    <= '0;
			first_beat <= 1'b0;
		end else if (state == ST_LOAD) begin
			col_cnt    <= line_words - 1'b1;
			row_cnt    <= cfg.height - 1'b1;
			first_beat <= 1'b1;
		end else if (rnext) begin
			first_beat <= 1'b0;
			if (col_cnt != '0) begin
				col_cnt <= col_cnt - 1'b1;
			end else begin
				col_cnt <= line_words - 1'b1;
				row_cnt <= row_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (rnext) begin
			beat_q.data <= M_AXI_RDATA;
			beat_q.sof  <= first_beat;
			beat_q.eol  <= (col_cnt == '0);
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			beat_seen <= 1'b0;
			push_q    <= 1'b0;
		end else begin
			beat_seen <= rnext;
			push_q    <= rnext && !dropping && !soft_reset_req;
		end
	end

	assign stream.push = push_q;
	assign stream.beat = beat_q;

	// Dropped beats free their reservation without spending a credit
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			credits  <= CNT_W'(FIFO_DEPTH);
			inflight <= '0;
		end else begin
			credits  <= credits - CNT_W'(push_q) + CNT_W'(stream.credit);
			inflight <= inflight + (start_burst ? CNT_W'(BURST_LEN) : '0) - CNT_W'(beat_seen);
		end
	end

	a_ar_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR))
		else $error("AR request changed before ARREADY");

	a_push_credit: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		stream.push |-> credits != '0)
		else $error("push issued with no FIFO credit left");

	a_rresp_okay: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		rnext |-> M_AXI_RRESP == 2'b00)
		else $error("read response error 0x%0h", M_AXI_RRESP);

endmodule

// File: mm2fifo/frame_reader_regs.sv
`timescale 1ns/1ps
/*
 * Frame reader configuration registers
 * Shadows base address and frame size at each frame start and tracks
 * the soft-reset sequence until the read master has gone idle.
 */
module frame_reader_regs import frame_reader_pkg::*; (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  soft_reset,
	input  logic [ADDR_WIDTH-1:0] cfg_base_addr,
	input  logic [IMG_WBITS-1:0]  cfg_width,
	input  logic [IMG_HBITS-1:0]  cfg_height,
	input  logic                  cfg_load,
	input  logic                  master_idle,
	output frame_cfg_t            cfg,
	output logic                  soft_reset_req,
	output logic                  resetting
);

	logic soft_reset_d;
	logic soft_rise;
	logic reset_busy;

	// --------------------------------------------------
	// Shadow configuration
	// --------------------------------------------------

	// Only updated at frame start, stable for the whole frame
	always_ff @(posedge M_AXI_ACLK) begin
		if (cfg_load) begin
			cfg <= '{
				base_addr: cfg_base_addr,
				width:     cfg_width,
				height:    cfg_height
			};
		end
	end

	// --------------------------------------------------
	// Soft reset sequencing
	// --------------------------------------------------
	assign soft_rise = soft_reset && !soft_reset_d;

	// Busy out of hard reset, cleared once the master is seen idle
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			soft_reset_d <= 1'b0;
			reset_busy   <= 1'b1;
		end else begin
			soft_reset_d <= soft_reset;
			if (soft_rise)
				reset_busy <= 1'b1;
			else if (master_idle)
				reset_busy <= 1'b0;
		end
	end

	// Edge goes straight through so the master stops in the same cycle
	assign soft_reset_req = soft_rise || reset_busy;
	assign resetting      = reset_busy;

endmodule

// File: common/frame_stream_if.sv
`timescale 1ns/1ps
/*
 * Beat stream from the read master into the FIFO
 * push qualifies beat for one cycle, credit returns one FIFO slot.
 */
interface frame_stream_if import frame_reader_pkg::*; #(
	parameter type beat_t = stream_beat_t
) ();

	logic  push;
	beat_t beat;
	logic  credit;

	// Producer side
	modport source (
		output push,
		output beat,
		input  credit
	);

	// Consumer side
	modport sink (
		input  push,
		input  beat,
		output credit
	);

endinterface

// File: common/frame_reader_pkg.sv
/*
 * Frame reader shared definitions
 * Bus and image sizing constants, the per-frame configuration record,
 * the stream beat record and small elaboration-time helpers.
 */
package frame_reader_pkg;

	localparam int ADDR_WIDTH  = 32;
	localparam int DATA_WIDTH  = 32;
	localparam int IMG_WBITS   = 12;
	localparam int IMG_HBITS   = 12;
	localparam int PIXEL_WIDTH = 8;

	// Frame geometry, latched once per frame
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] base_addr;
		logic [IMG_WBITS-1:0]  width;
		logic [IMG_HBITS-1:0]  height;
	} frame_cfg_t;

	// One bus word plus its frame markers
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic                  sof;
		logic                  eol;
	} stream_beat_t;

	// Bytes per pixel, rounded up to a power of two
	function automatic int pixel_bytes(input int bits);
		if (bits <= 8)
			return 1;
		else if (bits <= 16)
			return 2;
		return 4;
	endfunction

	// Bits needed to hold the given value
	function automatic int clog2_int(input int value);
		int v;
		int n;
		v = value;
		n = 0;
		while (v > 0) begin
			v = v >> 1;
			n++;
		end
		return n;
	endfunction

endpackage
